//--- sim.f
+incdir+verilog
verilog/sigdecode_types_pkg.sv
verilog/poly_mem_pkg.sv
verilog/poly_mem_if.sv
verilog/sigdecode_z_unit.sv
verilog/z_chunk_decoder.sv
verilog/poly_mem_arbiter.sv
verilog/poly_mem.sv
verilog/host_read_port.sv
verilog/sigdecode_z_top.sv
verification/sigdecode_z_checker.sv
verification/sigdecode_z_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the signature z decoder testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module sigdecode_z_tb -f sim.f -o sigdecode_z_sim

output=$(./obj_dir/sigdecode_z_sim)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- verification/sigdecode_z_tb.sv
/*
 * Testbench of the signature z decoder
 * Random and directed byte streams, host reads and zeroize against the scoreboard
 */
`timescale 1ns/1ns
`default_nettype none

module sigdecode_z_tb;

    localparam int Q            = 8380417;
    localparam int DONE_TIMEOUT = 64;
    localparam int READ_TIMEOUT = 64;

    logic        clk;
    logic        reset_n;
    logic        start_i;
    logic        zeroize_i;
    logic        byte_valid_i;
    logic [7:0]  byte_i;
    logic        done_o;
    logic        rd_req_i;
    logic [7:0]  rd_index_i;
    logic        rd_valid_o;
    logic [23:0] rd_data_o;

    logic [7:0]  test_id;
    logic        end_run;
    logic        summary_done;
    logic        checker_fail;
    int          tb_errors;
    int          seed;
    int          wait_cnt;
    // Byte string of the polynomial that is being sent
    logic [7:0]  poly_bytes [640];

    sigdecode_z_top sigdecode_z_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .zeroize_i    (zeroize_i),
        .byte_valid_i (byte_valid_i),
        .byte_i       (byte_i),
        .done_o       (done_o),
        .rd_req_i     (rd_req_i),
        .rd_index_i   (rd_index_i),
        .rd_valid_o   (rd_valid_o),
        .rd_data_o    (rd_data_o)
    );

    sigdecode_z_checker sigdecode_z_checker_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .zeroize_i      (zeroize_i),
        .byte_valid_i   (byte_valid_i),
        .byte_i         (byte_i),
        .dut_done_i     (done_o),
        .rd_req_i       (rd_req_i),
        .rd_index_i     (rd_index_i),
        .dut_rd_valid_i (rd_valid_o),
        .dut_rd_data_i  (rd_data_o),
        .test_id_i      (test_id),
        .tb_errors_i    (tb_errors),
        .end_i          (end_run),
        .summary_o      (summary_done),
        .fail_o         (checker_fail)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic pulse_start();
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic pulse_zeroize();
        @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < 640; i++) begin
            poly_bytes[10'(i)] = 8'($random(seed));
        end
    endtask

    // Raw values 0, 2^19, 2^19+1 and 2^20-1 as the first chunk
    task automatic load_directed_chunk();
        logic [79:0] bits;
        bits = {20'hFFFFF, 20'h80001, 20'h80000, 20'h00000};
        for (int i = 0; i < 10; i++) begin
            poly_bytes[10'(i)] = 8'(bits >> (8 * i));
        end
    endtask

    // Sends bytes first..last with up to max_gap idle cycles before each
    task automatic send_range(input int first, input int last, input int max_gap);
        int gap;
        for (int i = first; i <= last; i++) begin
            gap = 0;
            if (max_gap > 0) begin
                gap = int'($unsigned($random(seed)) % $unsigned(max_gap + 1));
            end
            repeat (gap) begin
                @(posedge clk);
                byte_valid_i <= 1'b0;
            end
            @(posedge clk);
            byte_valid_i <= 1'b1;
            byte_i       <= poly_bytes[10'(i)];
        end
        @(posedge clk);
        byte_valid_i <= 1'b0;
    endtask

    task automatic wait_done();
        int   cnt;
        logic seen;
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < DONE_TIMEOUT) begin
            @(posedge clk);
            seen = done_o;
            cnt++;
        end
        if (!seen) begin
            $display("Error: timed out waiting for done_o in test %0d", test_id);
            tb_errors++;
        end
    endtask

    // One read pulse, then wait for the valid pulse that ends it
    task automatic read_coeff(input int idx, output logic [23:0] data);
        int   cnt;
        logic seen;
        @(posedge clk);
        rd_req_i   <= 1'b1;
        rd_index_i <= 8'(idx);
        @(posedge clk);
        rd_req_i <= 1'b0;
        cnt  = 0;
        seen = 1'b0;
        data = '0;
        while (!seen && cnt < READ_TIMEOUT) begin
            @(posedge clk);
            if (rd_valid_o) begin
                seen = 1'b1;
                data = rd_data_o;
            end
            cnt++;
        end
        if (!seen) begin
            $display("Error: timed out waiting for rd_valid_o on coefficient %0d", idx);
            tb_errors++;
        end
    endtask

    task automatic read_range(input int first, input int last);
        logic [23:0] data;
        for (int i = first; i <= last; i++) begin
            read_coeff(i, data);
        end
    endtask

    // Done and read valid have to stay low while nothing is going on
    task automatic check_quiet(input int cycles);
        logic quiet;
        quiet = 1'b1;
        repeat (cycles) begin
            @(posedge clk);
            if (done_o !== 1'b0 || rd_valid_o !== 1'b0) begin
                quiet = 1'b0;
            end
        end
        if (!quiet) begin
            $display("Error: done_o or rd_valid_o went high with no stimulus in test %0d",
                     test_id);
            tb_errors++;
        end
    endtask

    task automatic check_directed();
        int          expected [4];
        logic [23:0] data;
        expected[0] = 1 << 19;
        expected[1] = 0;
        expected[2] = Q - 1;
        expected[3] = Q - (1 << 19) + 1;
        for (int k = 0; k < 4; k++) begin
            read_coeff(k, data);
            if (int'(data) != expected[2'(k)]) begin
                $display("Mismatch in directed_chunk: coefficient %0d expected %0d actual %0d",
                         k, expected[2'(k)], data);
                tb_errors++;
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        reset_n      = 1'b0;
        start_i      = 1'b0;
        zeroize_i    = 1'b0;
        byte_valid_i = 1'b0;
        byte_i       = 8'h00;
        rd_req_i     = 1'b0;
        rd_index_i   = 8'h00;
        test_id      = 8'd0;
        end_run      = 1'b0;
        tb_errors    = 0;
        seed         = 32'h3461_1363;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        test_id <= 8'd1;
        check_quiet(20);

        // Random polynomial without gaps, read back in full
        test_id <= 8'd2;
        fill_random();
        pulse_start();
        send_range(0, 639, 0);
        wait_done();
        read_range(0, 255);

        // New bytes with idle cycles in between so the store has to change
        test_id <= 8'd4;
        fill_random();
        pulse_start();
        send_range(0, 639, 3);
        wait_done();
        read_range(0, 255);

        test_id <= 8'd3;
        fill_random();
        load_directed_chunk();
        pulse_start();
        send_range(0, 639, 0);
        wait_done();
        check_directed();

        // Upper half read back while the lower half of a new polynomial streams in
        test_id <= 8'd5;
        fill_random();
        pulse_start();
        fork
            send_range(0, 319, 0);
            read_range(128, 255);
        join
        send_range(320, 639, 0);
        wait_done();
        read_range(0, 255);

        // Abort five bytes into the last chunk
        // The remaining five bytes must then not complete the polynomial
        test_id <= 8'd6;
        fill_random();
        pulse_start();
        send_range(0, 634, 0);
        pulse_zeroize();
        send_range(635, 639, 0);
        check_quiet(30);
        fill_random();
        pulse_start();
        send_range(0, 639, 0);
        wait_done();
        read_range(0, 255);

        @(posedge clk);
        end_run <= 1'b1;
        wait_cnt = 0;
        while (!summary_done && wait_cnt < 8) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (summary_done && !checker_fail) begin
            $display("Simulation passed");
        end else begin
            if (!summary_done) begin
                $display("Error: timed out waiting for the scoreboard summary");
            end
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/sigdecode_z_checker.sv
/*
 * Scoreboard of the signature z decoder
 * Models the coefficient store from the byte stream, checks reads and done pulses
 */
`timescale 1ns/1ns
`default_nettype none
`include "sigdecode_settings.svh"

module sigdecode_z_checker (
    input  wire logic        clk,
    input  wire logic        reset_n,
    input  wire logic        start_i,
    input  wire logic        zeroize_i,
    input  wire logic        byte_valid_i,
    input  wire logic [7:0]  byte_i,
    input  wire logic        dut_done_i,
    input  wire logic        rd_req_i,
    input  wire logic [7:0]  rd_index_i,
    input  wire logic        dut_rd_valid_i,
    input  wire logic [23:0] dut_rd_data_i,
    input  wire logic [7:0]  test_id_i,
    input  wire logic [31:0] tb_errors_i,
    input  wire logic        end_i,
    output logic             summary_o,
    output logic             fail_o
);

    // Expected store, one entry per coefficient index
    logic [23:0] image_q [256];
    logic [7:0]  chunk_bytes [10];
    logic [3:0]  byte_cnt;
    logic [5:0]  word_addr;
    logic        pend;
    logic        take;
    logic [7:0]  pend_idx;
    int          exp_done;
    int          done_cnt;
    int          mismatch_cnt;
    int          protocol_cnt;
    int          total;

    // Gamma1 - r, lifted by q when r is above gamma1
    function automatic logic [23:0] decode_raw(input logic [19:0] raw);
        int r;
        int gamma1;
        r      = int'(raw);
        gamma1 = 1 << `SIGDEC_GAMMA1_BITS;
        if (r <= gamma1) begin
            return 24'(gamma1 - r);
        end
        return 24'(`SIGDEC_Q + gamma1 - r);
    endfunction

    function automatic string test_label(input logic [7:0] id);
        case (id)
            8'd1:    return "reset_idle";
            8'd2:    return "random_poly";
            8'd3:    return "directed_chunk";
            8'd4:    return "random_gaps";
            8'd5:    return "reads_during_stream";
            8'd6:    return "zeroize_abort";
            default: return "setup";
        endcase
    endfunction

    // --------------------
    // Chunk model
    // --------------------
    // Ten bytes little endian, raw value k sits in bits 20k+19 down to 20k
    function automatic void store_chunk();
        logic [79:0] bits;
        bits = '0;
        for (int b = 9; b >= 0; b--) begin
            bits = {bits[71:0], chunk_bytes[4'(b)]};
        end
        for (int k = 0; k < 4; k++) begin
            image_q[{word_addr, 2'(k)}] = decode_raw(20'(bits >> (20 * k)));
        end
        // The 64th word closes a polynomial and the address wraps
        word_addr = word_addr + 6'd1;
        if (word_addr == 6'd0) begin
            exp_done++;
        end
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt  = '0;
            word_addr = '0;
            pend      = 1'b0;
            summary_o <= 1'b0;
            fail_o    <= 1'b0;
        end else begin
            // A byte strobed together with start or zeroize is dropped
            if (zeroize_i || start_i) begin
                byte_cnt  = '0;
                word_addr = '0;
            end else if (byte_valid_i) begin
                chunk_bytes[byte_cnt] = byte_i;
                if (byte_cnt == 4'd9) begin
                    store_chunk();
                    byte_cnt = '0;
                end else begin
                    byte_cnt = byte_cnt + 4'd1;
                end
            end

            if (dut_done_i) begin
                done_cnt++;
                if (done_cnt > exp_done) begin
                    protocol_cnt++;
                    $display("Error: done_o pulsed in %s with no completed polynomial",
                             test_label(test_id_i));
                end
            end

            // --------------------
            // Host reads
            // --------------------
            // A request is only taken while no read is outstanding
            take = rd_req_i && !pend;
            if (dut_rd_valid_i) begin
                if (!pend) begin
                    protocol_cnt++;
                    $display("Error: rd_valid_o pulsed in %s with no read outstanding",
                             test_label(test_id_i));
                end else if (dut_rd_data_i !== image_q[pend_idx]) begin
                    mismatch_cnt++;
                    $display("Mismatch in %s: coefficient %0d expected %0d actual %0d",
                             test_label(test_id_i), pend_idx, image_q[pend_idx],
                             dut_rd_data_i);
                end
                pend = 1'b0;
            end
            if (take) begin
                pend     = 1'b1;
                pend_idx = rd_index_i;
            end

            // The closing summary is printed once
            if (end_i && !summary_o) begin
                if (done_cnt != exp_done) begin
                    protocol_cnt++;
                    $display("Error: done_o pulsed %0d times but %0d polynomials completed",
                             done_cnt, exp_done);
                end
                if (pend) begin
                    protocol_cnt++;
                    $display("Error: a host read was still outstanding at the end");
                end
                total = mismatch_cnt + protocol_cnt + int'(tb_errors_i);
                $display("Errors: %0d total, %0d mismatches, %0d protocol, %0d testbench",
                         total, mismatch_cnt, protocol_cnt, tb_errors_i);
                fail_o    <= (total != 0);
                summary_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sigdecode_z_top.sv
/*
 * Signature z decoder top level
 * Byte input, chunk decoder, host read port and the shared polynomial RAM
 */
`timescale 1ns/1ns
`default_nettype none

module sigdecode_z_top (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  start_i,
    input  wire logic                  zeroize_i,
    input  wire logic                  byte_valid_i,
    input  wire logic [7:0]            byte_i,
    output logic                       done_o,
    input  wire logic                  rd_req_i,
    input  wire logic [7:0]            rd_index_i,
    output logic                       rd_valid_o,
    output sigdecode_types_pkg::coeff_t rd_data_o
);

    import poly_mem_pkg::*;

    // RAM port driven by the arbiter
    logic       ram_en;
    logic       ram_we;
    poly_addr_t ram_addr;
    poly_word_t ram_wdata;
    poly_word_t ram_rdata;

    // One bus per requester
    poly_mem_if dec_bus ();
    poly_mem_if host_bus ();

    // --------------------
    // Requesters
    // --------------------
    z_chunk_decoder u_decoder (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .zeroize_i    (zeroize_i),
        .byte_valid_i (byte_valid_i),
        .byte_i       (byte_i),
        .done_o       (done_o),
        .mem          (dec_bus.requester)
    );

    host_read_port u_read_port (
        .clk        (clk),
        .reset_n    (reset_n),
        .rd_req_i   (rd_req_i),
        .rd_index_i (rd_index_i),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .mem        (host_bus.requester)
    );

    // --------------------
    // Arbiter and RAM
    // --------------------
    poly_mem_arbiter u_arbiter (
        .clk         (clk),
        .reset_n     (reset_n),
        .dec         (dec_bus.arbiter),
        .host        (host_bus.arbiter),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    poly_mem u_mem (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

//--- verilog/host_read_port.sv
/*
 * Host read port
 * Fetches one coefficient by index through the arbiter and returns it with a valid pulse
 */
`timescale 1ns/1ns
`default_nettype none
`include "sigdecode_settings.svh"

module host_read_port (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  rd_req_i,
    input  wire logic [7:0]            rd_index_i,
    output logic                       rd_valid_o,
    output sigdecode_types_pkg::coeff_t rd_data_o,
    poly_mem_if.requester              mem
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_DATA
    } rd_state_e;

    rd_state_e  state_q;
    logic [7:0] index_q;

    // --------------------
    // Read sequence
    // --------------------
    // Requests are only taken when idle, one read is outstanding at most
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE: if (rd_req_i) state_q <= RD_REQ;
                // Stay here as long as the decoder holds the memory
                RD_REQ:  if (mem.gnt) state_q <= RD_DATA;
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == RD_IDLE && rd_req_i) begin
            index_q <= rd_index_i;
        end
    end

    // Upper index bits pick the word, the low two bits pick the lane
    assign mem.req   = (state_q == RD_REQ);
    assign mem.we    = 1'b0;
    assign mem.addr  = index_q[`SIGDEC_ADDR_BITS+1:2];
    assign mem.wdata = '0;

    // RAM data is valid in the cycle after the grant
    assign rd_valid_o = (state_q == RD_DATA);
    assign rd_data_o  = mem.rdata[index_q[1:0]];

endmodule

`default_nettype wire

//--- verilog/poly_mem.sv
/*
 * Polynomial store
 * Single port RAM of 64 words with four coefficients each
 */
`timescale 1ns/1ns
`default_nettype none
`include "sigdecode_settings.svh"

module poly_mem (
    input  wire logic                      clk,
    input  wire logic                      en_i,
    input  wire logic                      we_i,
    input  wire poly_mem_pkg::poly_addr_t  addr_i,
    input  wire poly_mem_pkg::poly_word_t  wdata_i,
    output poly_mem_pkg::poly_word_t       rdata_o
);

    import poly_mem_pkg::*;

    poly_word_t mem_q [`SIGDEC_POLY_WORDS];

    // One access per cycle
    // Reads land in the output register and show up the next cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/poly_mem_arbiter.sv
/*
 * Fixed priority arbiter on the polynomial memory
 * Decoder writes win over host reads, the winner drives the RAM
 */
`timescale 1ns/1ns
`default_nettype none

module poly_mem_arbiter (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    poly_mem_if.arbiter                    dec,
    poly_mem_if.arbiter                    host,
    output logic                           ram_en_o,
    output logic                           ram_we_o,
    output poly_mem_pkg::poly_addr_t       ram_addr_o,
    output poly_mem_pkg::poly_word_t       ram_wdata_o,
    input  wire poly_mem_pkg::poly_word_t  ram_rdata_i
);

    logic dec_gnt;
    logic host_gnt;
    logic dec_rd_q;
    logic host_rd_q;

    // Host only gets the RAM in cycles the decoder leaves free
    assign dec_gnt  = dec.req;
    assign host_gnt = host.req && !dec.req;

    assign dec.gnt  = dec_gnt;
    assign host.gnt = host_gnt;

    // --------------------
    // RAM side mux
    // --------------------
    assign ram_en_o    = dec.req || host.req;
    assign ram_we_o    = dec_gnt ? dec.we : host.we;
    assign ram_addr_o  = dec_gnt ? dec.addr : host.addr;
    assign ram_wdata_o = dec_gnt ? dec.wdata : host.wdata;

    // Remember who read so the registered RAM output goes to the right port
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dec_rd_q  <= 1'b0;
            host_rd_q <= 1'b0;
        end else begin
            dec_rd_q  <= dec_gnt && !dec.we;
            host_rd_q <= host_gnt && !host.we;
        end
    end

    assign dec.rdata  = dec_rd_q ? ram_rdata_i : '0;
    assign host.rdata = host_rd_q ? ram_rdata_i : '0;

endmodule

`default_nettype wire

//--- verilog/z_chunk_decoder.sv
/*
 * Chunk decoder for the z field
 * Packs incoming bytes into chunks, decodes four lanes and writes one word per chunk
 */
`timescale 1ns/1ns
`default_nettype none
`include "sigdecode_settings.svh"

module z_chunk_decoder (
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic       start_i,
    input  wire logic       zeroize_i,
    input  wire logic       byte_valid_i,
    input  wire logic [7:0] byte_i,
    output logic            done_o,
    poly_mem_if.requester   mem
);

    import sigdecode_types_pkg::*;
    import poly_mem_pkg::*;

    logic [3:0] byte_cnt_q;
    logic       byte_accept;
    logic       last_byte;
    z_chunk_u   asm_d;
    z_chunk_u   asm_q;
    z_chunk_u   chunk_q;
    logic       chunk_vld_q;
    logic       s1_vld_q;
    poly_addr_t word_addr_q;
    poly_word_t word_d;
    logic       wr_fire;

    // --------------------
    // Byte assembly
    // --------------------
    // Start and zeroize take the cycle so a byte strobed with them is dropped
    assign byte_accept = byte_valid_i && !start_i && !zeroize_i;
    assign last_byte   = byte_accept && (byte_cnt_q == 4'(`SIGDEC_CHUNK_BYTES - 1));

    // The incoming byte goes straight into its slot of the byte view
    always_comb begin
        asm_d = asm_q;
        asm_d.bytes[byte_cnt_q] = byte_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt_q <= '0;
        end else if (zeroize_i || start_i) begin
            byte_cnt_q <= '0;
        end else if (byte_accept) begin
            byte_cnt_q <= last_byte ? 4'd0 : byte_cnt_q + 4'd1;
        end
    end

    // Partial chunk is wiped on zeroize
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            asm_q <= '0;
        end else if (byte_accept) begin
            asm_q <= asm_d;
        end
    end

    // The completed chunk moves out so the next chunk can start with no gap
    always_ff @(posedge clk) begin
        if (last_byte) begin
            chunk_q <= asm_d;
        end
    end

    // --------------------
    // Decode lanes
    // --------------------
    for (genvar k = 0; k < `SIGDEC_LANES; k++) begin : g_lane
        sigdecode_z_unit u_unit (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .data_i    (chunk_q.raw[k]),
            .data_o    (word_d[k])
        );
    end

    // Valid follows the chunk through the loaded chunk and the lane stage 1
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            chunk_vld_q <= 1'b0;
            s1_vld_q    <= 1'b0;
        end else if (zeroize_i) begin
            chunk_vld_q <= 1'b0;
            s1_vld_q    <= 1'b0;
        end else begin
            chunk_vld_q <= last_byte;
            s1_vld_q    <= chunk_vld_q;
        end
    end

    // --------------------
    // Memory write
    // --------------------
    // The decoder has priority so the request is granted in the cycle it rises
    assign mem.req   = s1_vld_q;
    assign mem.we    = 1'b1;
    assign mem.addr  = word_addr_q;
    assign mem.wdata = word_d;

    assign wr_fire = mem.req && mem.gnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            word_addr_q <= '0;
        end else if (zeroize_i || start_i) begin
            word_addr_q <= '0;
        end else if (wr_fire) begin
            word_addr_q <= word_addr_q + poly_addr_t'(1);
        end
    end

    // Completion shows in the same cycle as the grant of the last word
    assign done_o = wr_fire && (word_addr_q == poly_addr_t'(`SIGDEC_POLY_WORDS - 1));

endmodule

`default_nettype wire

//--- verilog/sigdecode_z_unit.sv
/*
 * Decode lane for one raw z value
 * Two stage computation of gamma1 - r mod q
 */
`timescale 1ns/1ns
`default_nettype none
`include "sigdecode_settings.svh"

module sigdecode_z_unit (
    input  wire logic                       clk,
    input  wire logic                       reset_n,
    input  wire logic                       zeroize_i,
    input  wire sigdecode_types_pkg::z_raw_t data_i,
    output sigdecode_types_pkg::coeff_t      data_o
);

    localparam int W = `SIGDEC_REG_SIZE;
    localparam logic [W-1:0] GAMMA1 = W'(1) << `SIGDEC_GAMMA1_BITS;
    localparam logic [W-1:0] Q      = W'(`SIGDEC_Q);

    logic [W-1:0] opb0;
    logic [W:0]   sum0;
    logic [W-1:0] diff_q;
    logic         carry_q;
    logic [W-1:0] corr;

    // --------------------
    // Stage 1
    // --------------------
    // Subtraction as gamma1 plus the inverted raw value plus one
    assign opb0 = ~{{(W - `SIGDEC_Z_BITS){1'b0}}, data_i};
    assign sum0 = {1'b0, GAMMA1} + {1'b0, opb0} + {{W{1'b0}}, 1'b1};

    // A carry out means no borrow, so the difference is already non negative
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            diff_q  <= '0;
            carry_q <= 1'b0;
        end else if (zeroize_i) begin
            diff_q  <= '0;
            carry_q <= 1'b0;
        end else begin
            diff_q  <= sum0[W-1:0];
            carry_q <= sum0[W];
        end
    end

    // --------------------
    // Stage 2
    // --------------------
    // A negative difference wraps modulo 2^23 and adding q brings it back into range
    assign corr = diff_q + Q;

    // Result lies in [0, q) so the extra top bit is always zero
    assign data_o = {1'b0, carry_q ? diff_q : corr};

endmodule

`default_nettype wire

//--- verilog/poly_mem_if.sv
/*
 * Polynomial memory bus of one requester
 * Request, write and address fields from the requester, grant and data back
 */
`timescale 1ns/1ns
`default_nettype none

interface poly_mem_if;

    import poly_mem_pkg::*;

    // Requester side
    // Req and the fields stay put until gnt is seen in the same cycle
    logic       req;
    logic       we;
    poly_addr_t addr;
    poly_word_t wdata;

    // Arbiter side
    // Read data shows up one cycle after the granted read
    logic       gnt;
    poly_word_t rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

//--- verilog/poly_mem_pkg.sv
/*
 * Polynomial store types
 * Word and address formats of the 64 word coefficient memory
 */
`default_nettype none
`include "sigdecode_settings.svh"

package poly_mem_pkg;

    import sigdecode_types_pkg::*;

    // Four coefficients per word
    // Lane k of the word at address a holds coefficient 4*a + k
    typedef coeff_t [`SIGDEC_LANES-1:0] poly_word_t;

    // Word address into the store
    typedef logic [`SIGDEC_ADDR_BITS-1:0] poly_addr_t;

endpackage

`default_nettype wire

//--- verilog/sigdecode_types_pkg.sv
/*
 * Data types of the signature z decoder
 * Raw packed values, decoded coefficients and the ten byte chunk
 */
`default_nettype none
`include "sigdecode_settings.svh"

package sigdecode_types_pkg;

    // One raw value as it sits in the packed byte string
    typedef logic [`SIGDEC_Z_BITS-1:0] z_raw_t;

    // Decoded coefficient, always below q so the top bit stays zero
    typedef logic [`SIGDEC_COEFF_BITS-1:0] coeff_t;

    // --------------------
    // Chunk of the byte string
    // --------------------
    // Bytes arrive one at a time and are stored by position in the byte view
    // The decode lanes pick up the same bits as four raw values
    // Byte 0 lands in bits 7..0 so the raw values come out little endian
    typedef union packed {
        logic [`SIGDEC_CHUNK_BYTES-1:0][7:0] bytes;
        z_raw_t [`SIGDEC_LANES-1:0]          raw;
    } z_chunk_u;

endpackage

`default_nettype wire

//--- verilog/sigdecode_settings.svh
/*
 * Signature z decoder constants
 * Modulus, gamma1 exponent, datapath widths and polynomial store sizes
 */
`ifndef SIGDECODE_SETTINGS_SVH
`define SIGDECODE_SETTINGS_SVH

// Prime modulus of the coefficient ring
`define SIGDEC_Q            8380417
// Gamma1 is a power of two and only its exponent is kept
`define SIGDEC_GAMMA1_BITS  19
`define SIGDEC_Z_BITS       20
// Internal adder width, one bit narrower than a stored coefficient
`define SIGDEC_REG_SIZE     23
`define SIGDEC_COEFF_BITS   24

// Ten bytes carry four 20-bit raw values
`define SIGDEC_CHUNK_BYTES  10
`define SIGDEC_LANES        4
`define SIGDEC_POLY_WORDS   64
`define SIGDEC_ADDR_BITS    6

`endif
